/* build.f */
logic/cpu_pkg.sv
logic/register_file.sv
logic/alu.sv
logic/sequencer.sv
logic/cpu.sv
bench/bench_memory.sv
bench/cpu_bench.sv

/* Bender.yml */
package:
  name: cpu

sources:
  - logic/cpu_pkg.sv
  - logic/register_file.sv
  - logic/alu.sv
  - logic/sequencer.sv
  - logic/cpu.sv
  - target: simulation
    files:
      - bench/bench_memory.sv
      - bench/cpu_bench.sv

/* bench/cpu_bench.sv */
`timescale 1ns/100ps

module cpu_bench;

    localparam cpu_pkg::word_t reset_vector = 32'h0000_0040;
    localparam int alu_count = 24;
    localparam int margin_ns = 2000;

    logic clock;
    logic clear;
    cpu_pkg::word_t adr;
    cpu_pkg::word_t dat_w;
    cpu_pkg::word_t dat_r;
    logic we;
    logic stb;
    logic cyc;
    logic ack;
    logic halted;

    cpu_pkg::word_t image [0:1023];
    cpu_pkg::word_t expected_addresses [$];
    cpu_pkg::word_t expected_values [$];
    cpu_pkg::word_t expected_fetches [$];
    int program_length;
    logic [15:0] data_address;
    int error_count = 0;
    int stores_checked = 0;
    int fetches_checked = 0;
    int expected_fetch_count = 0;
    logic reference_ready = 1'b0;
    logic bus_open = 1'b0;

    cpu #(
        .reset_vector(reset_vector)
    ) cpu_inst (
        .clock(clock),
        .clear(clear),
        .adr(adr),
        .dat_w(dat_w),
        .dat_r(dat_r),
        .we(we),
        .stb(stb),
        .cyc(cyc),
        .ack(ack),
        .halted(halted)
    );

    bench_memory memory_inst (
        .clock(clock),
        .clear(clear),
        .adr(adr),
        .dat_w(dat_w),
        .dat_r(dat_r),
        .we(we),
        .stb(stb),
        .cyc(cyc),
        .ack(ack)
    );

    initial
    begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic cpu_pkg::word_t encode(logic [5:0] op, cpu_pkg::index_t a,
        cpu_pkg::index_t b, cpu_pkg::index_t d, logic high, logic [15:0] imm);
        cpu_pkg::word_t w;
        w = '0;
        w[cpu_pkg::opcode_lsb +: 6] = op;
        w[cpu_pkg::source_a_lsb +: 3] = a;
        w[cpu_pkg::source_b_lsb +: 3] = b;
        w[cpu_pkg::destination_lsb +: 3] = d;
        w[cpu_pkg::high_half_bit] = high;
        w[cpu_pkg::immediate_lsb +: 16] = imm;
        return w;
    endfunction

    function automatic logic [5:0] pick_alu_op(int unsigned pick);
        case (pick % 6)
            0: return cpu_pkg::add_op;
            1: return cpu_pkg::sub_op;
            2: return cpu_pkg::and_op;
            3: return cpu_pkg::or_op;
            4: return cpu_pkg::xor_op;
            default: return cpu_pkg::cmp_eq_op;
        endcase
    endfunction

    function automatic cpu_pkg::index_t random_index();
        return cpu_pkg::index_t'($urandom % 8);
    endfunction

    function automatic logic [15:0] here();
        return reset_vector[15:0] + program_length[15:0];
    endfunction

    task automatic emit(cpu_pkg::word_t w);
        image[reset_vector + program_length] = w;
        program_length++;
    endtask

    task automatic load_word(cpu_pkg::index_t d, cpu_pkg::word_t value);
        emit(encode(cpu_pkg::load_imm_op, 0, 0, d, 1'b0, value[15:0]));
        emit(encode(cpu_pkg::load_imm_op, d, 0, d, 1'b1, value[31:16]));
    endtask

    task automatic store_register(cpu_pkg::index_t r);
        emit(encode(cpu_pkg::store_op, r, 0, 0, 1'b0, data_address));
        data_address++;
    endtask

    task automatic build_program();
        for (int i = 0; i < 1024; i++)
            image[i] = {i[15:0] ^ 16'hbeef, i[15:0]};
        program_length = 0;
        data_address = 16'h0300;
        for (int r = 0; r < 8; r++)
            load_word(r, $urandom);
        for (int i = 0; i < alu_count; i++)
            emit(encode(pick_alu_op($urandom), random_index(), random_index(),
                random_index(), 1'b0, 16'h0));
        // force a zero result and an equal compare
        emit(encode(cpu_pkg::xor_op, 3, 3, 5, 1'b0, 16'h0));
        emit(encode(cpu_pkg::cmp_eq_op, 2, 2, 6, 1'b0, 16'h0));
        // low-only load, then a high load taking the lower half of another register
        emit(encode(cpu_pkg::load_imm_op, 0, 0, 7, 1'b0, 16'h8001));
        emit(encode(cpu_pkg::load_imm_op, 6, 0, 1, 1'b1, 16'h7e57));
        for (int r = 0; r < 8; r++)
            store_register(r);
        // each flag either skips or lets through a store of r0
        for (int f = 0; f < 8; f++)
        begin
            emit(encode(cpu_pkg::branch_op, f, 0, 0, 1'b0, here() + 16'd2));
            store_register(0);
        end
        emit(encode(cpu_pkg::load_imm_op, 0, 0, 1, 1'b0, 16'h0000));
        emit(encode(cpu_pkg::load_imm_op, 0, 0, 2, 1'b0, 16'h0005));
        emit(encode(cpu_pkg::load_imm_op, 0, 0, 3, 1'b0, 16'h00a1));
        emit(encode(cpu_pkg::load_imm_op, 0, 0, 4, 1'b0, 16'h00b2));
        emit(encode(cpu_pkg::load_imm_op, 0, 0, 5, 1'b0, 16'h00c3));
        emit(encode(cpu_pkg::load_imm_op, 0, 0, 6, 1'b0, 16'h00d4));
        // taken branch skips a1, untaken keeps b2, jump skips c3 and lands on d4
        emit(encode(cpu_pkg::branch_op, 1, 0, 0, 1'b0, here() + 16'd2));
        store_register(3);
        emit(encode(cpu_pkg::branch_op, 2, 0, 0, 1'b0, here() + 16'd3));
        store_register(4);
        emit(encode(cpu_pkg::jump_op, 0, 0, 0, 1'b0, here() + 16'd2));
        store_register(5);
        store_register(6);
        emit(encode(cpu_pkg::halt_op, 0, 0, 0, 1'b0, 16'h0));
        store_register(7);
    endtask

    // instruction-set model that fills the expected queues and returns the fetch count
    function automatic int run_reference();
        cpu_pkg::word_t regs [8];
        logic flags [8];
        cpu_pkg::word_t pc;
        cpu_pkg::word_t w;
        cpu_pkg::word_t a;
        cpu_pkg::word_t b;
        cpu_pkg::word_t value;
        logic flag;
        logic write;
        logic done;
        logic [5:0] op;
        logic [15:0] imm;
        int fetches;
        for (int i = 0; i < 8; i++)
        begin
            regs[i] = '0;
            flags[i] = 1'b0;
        end
        pc = reset_vector;
        fetches = 0;
        done = 1'b0;
        while (!done && fetches < 1000)
        begin
            w = image[pc[9:0]];
            expected_fetches.push_back(pc);
            fetches++;
            op = w[cpu_pkg::opcode_lsb +: 6];
            a = regs[w[cpu_pkg::source_a_lsb +: 3]];
            b = regs[w[cpu_pkg::source_b_lsb +: 3]];
            imm = w[cpu_pkg::immediate_lsb +: 16];
            pc = pc + 1;
            write = 1'b1;
            value = '0;
            flag = 1'b0;
            case (op)
                cpu_pkg::add_op:
                begin
                    value = a + b;
                    flag = (value < a);
                end
                cpu_pkg::sub_op:
                begin
                    value = a - b;
                    flag = (a < b);
                end
                cpu_pkg::and_op:
                    value = a & b;
                cpu_pkg::or_op:
                    value = a | b;
                cpu_pkg::xor_op:
                    value = a ^ b;
                cpu_pkg::cmp_eq_op:
                begin
                    value = b;
                    flag = (a == b);
                end
                cpu_pkg::load_imm_op:
                    value = w[cpu_pkg::high_half_bit] ? {imm, a[15:0]} : {16'h0, imm};
                cpu_pkg::store_op:
                begin
                    expected_addresses.push_back({16'h0, imm});
                    expected_values.push_back(a);
                    write = 1'b0;
                end
                cpu_pkg::branch_op:
                begin
                    if (flags[w[cpu_pkg::source_a_lsb +: 3]])
                        pc = {16'h0, imm};
                    write = 1'b0;
                end
                cpu_pkg::jump_op:
                begin
                    pc = {16'h0, imm};
                    write = 1'b0;
                end
                cpu_pkg::halt_op:
                begin
                    done = 1'b1;
                    write = 1'b0;
                end
                default:
                    write = 1'b0;
            endcase
            // logic ops and load immediate flag a zero result
            if (op == cpu_pkg::and_op || op == cpu_pkg::or_op || op == cpu_pkg::xor_op
                || op == cpu_pkg::load_imm_op)
                flag = (value == '0);
            if (write)
            begin
                regs[w[cpu_pkg::destination_lsb +: 3]] = value;
                flags[w[cpu_pkg::destination_lsb +: 3]] = flag;
            end
        end
        return fetches;
    endfunction

    task automatic check_word(string name, cpu_pkg::word_t expected, cpu_pkg::word_t actual);
        assert (expected == actual)
        else
        begin
            error_count++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_true(logic condition, string text);
        assert (condition)
        else
        begin
            error_count++;
            $display("%s", text);
        end
    endtask

    task automatic check_store(cpu_pkg::word_t address, cpu_pkg::word_t value);
        check_true(stores_checked < expected_addresses.size(),
            $sformatf("unexpected store of %h to address %h", value, address));
        if (stores_checked < expected_addresses.size())
        begin
            check_word($sformatf("store %0d address", stores_checked),
                expected_addresses[stores_checked], address);
            check_word($sformatf("store %0d data", stores_checked),
                expected_values[stores_checked], value);
        end
        stores_checked++;
    endtask

    task automatic check_fetch(cpu_pkg::word_t address);
        check_true(fetches_checked < expected_fetches.size(),
            $sformatf("unexpected fetch from address %h", address));
        if (fetches_checked < expected_fetches.size())
            check_word($sformatf("fetch %0d address", fetches_checked),
                expected_fetches[fetches_checked], address);
        fetches_checked++;
    endtask

    task automatic print_totals();
        $display("errors %0d, stores checked %0d, fetches checked %0d",
            error_count, stores_checked, fetches_checked);
    endtask

    // compare and bus monitor sample away from the rising edge
    always @(negedge clock)
    begin
        while (memory_inst.store_addresses.size() > 0)
            check_store(memory_inst.store_addresses.pop_front(),
                memory_inst.store_values.pop_front());
        while (memory_inst.fetch_addresses.size() > 0)
            check_fetch(memory_inst.fetch_addresses.pop_front());
        if (clear)
            check_true(!cyc && !stb && !we && !halted, "bus or halted active during clear");
        check_true(cyc == stb, "cyc and stb differ");
        if (bus_open)
            check_true(cyc && stb, "stb or cyc dropped before ack");
        if (halted)
            check_true(!stb, "stb raised after halt");
        bus_open = stb && !ack && !clear;
    end

    initial
    begin
        int unsigned seed;
        clear = 1'b1;
        seed = $urandom(32'h64b1);
        build_program();
        for (int i = 0; i < 1024; i++)
            memory_inst.contents[i] = image[i];
        expected_fetch_count = run_reference();
        reference_ready = 1'b1;
        repeat (2) @(posedge clock);
        clear <= 1'b0;
        @(negedge clock);
        check_true(!cyc && !stb && !we && !halted, "bus or halted active on release of clear");
        @(negedge clock);
        check_true(cyc && stb && !we, "first fetch did not start right after clear");
        check_word("reset vector", reset_vector, adr);
        wait (halted);
        repeat (20) @(negedge clock);
        check_true(stores_checked == expected_addresses.size(),
            $sformatf("cpu made %0d stores where %0d were expected",
                stores_checked, expected_addresses.size()));
        check_true(fetches_checked == expected_fetch_count,
            $sformatf("cpu made %0d fetches where %0d were expected",
                fetches_checked, expected_fetch_count));
        print_totals();
        if (error_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    // watchdog allows 12 cycles per instruction
    initial
    begin
        wait (reference_ready);
        #(expected_fetch_count * 12 * 20 + margin_ns);
        $display("timeout: cpu did not halt within the time for %0d instructions",
            expected_fetch_count);
        print_totals();
        $display("Checks failed");
        $finish;
    end

endmodule

/* bench/bench_memory.sv */
`timescale 1ns/100ps

// wishbone classic slave holding program and data with an ack 1 to 4 cycles after stb
module bench_memory (
    input  logic           clock,
    input  logic           clear,
    input  cpu_pkg::word_t adr,
    input  cpu_pkg::word_t dat_w,
    output cpu_pkg::word_t dat_r,
    input  logic           we,
    input  logic           stb,
    input  logic           cyc,
    output logic           ack
);

    cpu_pkg::word_t contents [0:1023];
    cpu_pkg::word_t store_addresses [$];
    cpu_pkg::word_t store_values [$];
    cpu_pkg::word_t fetch_addresses [$];
    logic pending;
    int unsigned delay;

    always @(posedge clock or posedge clear)
    begin
        if (clear)
        begin
            ack <= 1'b0;
            dat_r <= '0;
            pending <= 1'b0;
            delay <= 0;
        end
        else
        begin
            ack <= 1'b0;
            // the cycle after ack still shows stb, so ack guards a new request
            if (cyc && stb && !ack && !pending)
            begin
                pending <= 1'b1;
                delay <= $urandom % 4;
            end
            else if (pending && delay != 0)
            begin
                delay <= delay - 1;
            end
            else if (pending)
            begin
                pending <= 1'b0;
                ack <= 1'b1;
                if (we)
                begin
                    contents[adr[9:0]] <= dat_w;
                    store_addresses.push_back(adr);
                    store_values.push_back(dat_w);
                end
                else
                begin
                    dat_r <= contents[adr[9:0]];
                    fetch_addresses.push_back(adr);
                end
            end
        end
    end

endmodule

/* logic/cpu.sv */
`timescale 1ns/100ps

module cpu #(
    parameter cpu_pkg::word_t reset_vector = '0
) (
    input  logic           clock,
    input  logic           clear,
    output cpu_pkg::word_t adr,
    output cpu_pkg::word_t dat_w,
    input  cpu_pkg::word_t dat_r,
    output logic           we,
    output logic           stb,
    output logic           cyc,
    input  logic           ack,
    output logic           halted
);

    cpu_pkg::opcode_e opcode;
    cpu_pkg::index_t source_a;
    cpu_pkg::index_t source_b;
    cpu_pkg::index_t destination;
    logic [15:0] immediate;
    logic high_half;
    logic write_enable;
    cpu_pkg::word_t operand_b;
    cpu_pkg::word_t result;
    cpu_pkg::flag_t flag_out;
    cpu_pkg::flag_t branch_flag;

    sequencer #(
        .reset_vector(reset_vector)
    ) sequencer_inst (
        .clock(clock),
        .clear(clear),
        .adr(adr),
        .we(we),
        .stb(stb),
        .cyc(cyc),
        .ack(ack),
        .dat_r(dat_r),
        .opcode(opcode),
        .source_a(source_a),
        .source_b(source_b),
        .destination(destination),
        .immediate(immediate),
        .high_half(high_half),
        .branch_flag(branch_flag),
        .write_enable(write_enable),
        .halted(halted)
    );

    // port a of the word file is both operand a and the store data
    alu alu_inst (
        .opcode(opcode),
        .operand_a(dat_w),
        .operand_b(operand_b),
        .immediate(immediate),
        .high_half(high_half),
        .result(result),
        .flag_out(flag_out)
    );

    register_file #(
        .entry_t(cpu_pkg::word_t)
    ) word_file_inst (
        .clock(clock),
        .clear(clear),
        .write_enable(write_enable),
        .write_index(destination),
        .write_data(result),
        .read_index_a(source_a),
        .read_data_a(dat_w),
        .read_index_b(source_b),
        .read_data_b(operand_b)
    );

    // flags only need port a, for branches
    register_file #(
        .entry_t(cpu_pkg::flag_t)
    ) flag_file_inst (
        .clock(clock),
        .clear(clear),
        .write_enable(write_enable),
        .write_index(destination),
        .write_data(flag_out),
        .read_index_a(source_a),
        .read_data_a(branch_flag),
        .read_index_b(source_b),
        .read_data_b()
    );

endmodule

/* logic/sequencer.sv */
`timescale 1ns/100ps

// fetch, execute, advance control with the wishbone master side
module sequencer #(
    parameter cpu_pkg::word_t reset_vector = '0
) (
    input  logic             clock,
    input  logic             clear,
    output cpu_pkg::word_t   adr,
    output logic             we,
    output logic             stb,
    output logic             cyc,
    input  logic             ack,
    input  cpu_pkg::word_t   dat_r,
    output cpu_pkg::opcode_e opcode,
    output cpu_pkg::index_t  source_a,
    output cpu_pkg::index_t  source_b,
    output cpu_pkg::index_t  destination,
    output logic [15:0]      immediate,
    output logic             high_half,
    input  cpu_pkg::flag_t   branch_flag,
    output logic             write_enable,
    output logic             halted
);

    typedef enum logic [1:0]
    {
        fetch_state,
        execute_state,
        advance_state,
        halted_state
    } state_e;

    state_e state;
    cpu_pkg::word_t program_counter;
    cpu_pkg::word_t instruction;
    cpu_pkg::word_t immediate_address;
    cpu_pkg::word_t next_counter;
    logic bus_active;
    logic write_active;
    logic writes_register;
    logic is_store;

    // field decode
    assign opcode = cpu_pkg::opcode_e'(instruction[cpu_pkg::opcode_lsb +: 6]);
    assign source_a = instruction[cpu_pkg::source_a_lsb +: $bits(cpu_pkg::index_t)];
    assign source_b = instruction[cpu_pkg::source_b_lsb +: $bits(cpu_pkg::index_t)];
    assign destination = instruction[cpu_pkg::destination_lsb +: $bits(cpu_pkg::index_t)];
    assign high_half = instruction[cpu_pkg::high_half_bit];
    assign immediate = instruction[cpu_pkg::immediate_lsb +: 16];

    assign immediate_address = {{(cpu_pkg::word_width - 16){1'b0}}, immediate};
    assign is_store = (opcode == cpu_pkg::store_op);

    always_comb
    begin
        case (opcode)
            cpu_pkg::add_op, cpu_pkg::sub_op, cpu_pkg::and_op, cpu_pkg::or_op,
            cpu_pkg::xor_op, cpu_pkg::load_imm_op, cpu_pkg::cmp_eq_op:
                writes_register = 1'b1;
            default:
                writes_register = 1'b0;
        endcase
    end

    // branch tests the flag selected by source a
    always_comb
    begin
        case (opcode)
            cpu_pkg::jump_op:
                next_counter = immediate_address;
            cpu_pkg::branch_op:
                next_counter = branch_flag ? immediate_address
                                           : program_counter + cpu_pkg::word_t'(1);
            default:
                next_counter = program_counter + cpu_pkg::word_t'(1);
        endcase
    end

    assign write_enable = (state == execute_state) && writes_register;
    assign adr = (state == execute_state) ? immediate_address : program_counter;
    assign cyc = bus_active;
    assign stb = bus_active;
    assign we = write_active;
    assign halted = (state == halted_state);

    always_ff @(posedge clock or posedge clear)
    begin
        if (clear)
        begin
            state <= fetch_state;
            program_counter <= reset_vector;
            bus_active <= 1'b0;
            write_active <= 1'b0;
        end
        else
        begin
            case (state)
                fetch_state:
                begin
                    if (!bus_active)
                    begin
                        bus_active <= 1'b1;
                    end
                    else if (ack)
                    begin
                        bus_active <= 1'b0;
                        state <= execute_state;
                    end
                end
                execute_state:
                begin
                    if (!is_store)
                    begin
                        state <= advance_state;
                    end
                    else if (!bus_active)
                    begin
                        bus_active <= 1'b1;
                        write_active <= 1'b1;
                    end
                    else if (ack)
                    begin
                        bus_active <= 1'b0;
                        write_active <= 1'b0;
                        state <= advance_state;
                    end
                end
                advance_state:
                begin
                    if (opcode == cpu_pkg::halt_op)
                    begin
                        state <= halted_state;
                    end
                    else
                    begin
                        // next fetch starts straight away
                        program_counter <= next_counter;
                        bus_active <= 1'b1;
                        state <= fetch_state;
                    end
                end
                default:
                    state <= halted_state;
            endcase
        end
    end

    always_ff @(posedge clock)
    begin
        if (state == fetch_state && bus_active && ack)
        begin
            instruction <= dat_r;
        end
    end

endmodule

/* logic/alu.sv */
`timescale 1ns/100ps

module alu (
    input  cpu_pkg::opcode_e opcode,
    input  cpu_pkg::word_t   operand_a,
    input  cpu_pkg::word_t   operand_b,
    input  logic [15:0]      immediate,
    input  logic             high_half,
    output cpu_pkg::word_t   result,
    output cpu_pkg::flag_t   flag_out
);

    logic [cpu_pkg::word_width:0] sum;
    logic [cpu_pkg::word_width:0] difference;
    cpu_pkg::word_t loaded;

    // extra top bit holds carry and borrow
    assign sum = {1'b0, operand_a} + {1'b0, operand_b};
    assign difference = {1'b0, operand_a} - {1'b0, operand_b};

    // high form keeps the lower half of source a
    assign loaded = high_half ? {immediate, operand_a[15:0]}
                              : {{(cpu_pkg::word_width - 16){1'b0}}, immediate};

    always_comb
    begin
        result = '0;
        flag_out = 1'b0;
        case (opcode)
            cpu_pkg::add_op:
            begin
                result = sum[cpu_pkg::word_width-1:0];
                flag_out = sum[cpu_pkg::word_width];
            end
            cpu_pkg::sub_op:
            begin
                result = difference[cpu_pkg::word_width-1:0];
                flag_out = difference[cpu_pkg::word_width];
            end
            cpu_pkg::and_op:
            begin
                result = operand_a & operand_b;
                flag_out = (result == '0);
            end
            cpu_pkg::or_op:
            begin
                result = operand_a | operand_b;
                flag_out = (result == '0);
            end
            cpu_pkg::xor_op:
            begin
                result = operand_a ^ operand_b;
                flag_out = (result == '0);
            end
            cpu_pkg::cmp_eq_op:
            begin
                // value passes through, flag carries the comparison
                result = operand_b;
                flag_out = (operand_a == operand_b);
            end
            cpu_pkg::load_imm_op:
            begin
                result = loaded;
                flag_out = (loaded == '0);
            end
            default:
            begin
                result = '0;
                flag_out = 1'b0;
            end
        endcase
    end

endmodule

/* logic/register_file.sv */
`timescale 1ns/100ps

// eight entries, one write port and two combinational read ports
module register_file #(
    parameter type entry_t = cpu_pkg::word_t
) (
    input  logic            clock,
    input  logic            clear,
    input  logic            write_enable,
    input  cpu_pkg::index_t write_index,
    input  entry_t          write_data,
    input  cpu_pkg::index_t read_index_a,
    output entry_t          read_data_a,
    input  cpu_pkg::index_t read_index_b,
    output entry_t          read_data_b
);

    entry_t entries [cpu_pkg::register_count];

    always_ff @(posedge clock or posedge clear)
    begin
        if (clear)
        begin
            for (int i = 0; i < cpu_pkg::register_count; i++)
            begin
                entries[i] <= '0;
            end
        end
        else if (write_enable)
        begin
            entries[write_index] <= write_data;
        end
    end

    // reads see the old value during the writing cycle
    assign read_data_a = entries[read_index_a];
    assign read_data_b = entries[read_index_b];

endmodule

/* logic/cpu_pkg.sv */
package cpu_pkg;

    // width of data and of word addresses
    localparam int word_width = 32;

    localparam int register_count = 8;

    typedef logic [word_width-1:0] word_t;
    typedef logic flag_t;
    typedef logic [2:0] index_t;

    // codes not listed here execute as nop
    typedef enum logic [5:0]
    {
        nop_op      = 6'd0,
        add_op      = 6'd1,
        sub_op      = 6'd2,
        and_op      = 6'd3,
        or_op       = 6'd4,
        xor_op      = 6'd5,
        load_imm_op = 6'd6,
        store_op    = 6'd7,
        cmp_eq_op   = 6'd8,
        branch_op   = 6'd9,
        jump_op     = 6'd10,
        halt_op     = 6'd63
    } opcode_e;

    // instruction word layout
    //   [5:0]   opcode
    //   [8:6]   source a
    //   [11:9]  source b
    //   [14:12] destination
    //   [15]    high half select for load immediate
    //   [31:16] immediate
    localparam int opcode_lsb = 0;
    localparam int source_a_lsb = 6;
    localparam int source_b_lsb = 9;
    localparam int destination_lsb = 12;
    localparam int high_half_bit = 15;
    localparam int immediate_lsb = 16;

endpackage
